// ==== src/exec_pkg.sv ====
// ==========================================================
// Shared widths, opcodes and the Wishbone address map of the
// execution unit. Imported by every RTL module of the core.
// ==========================================================
`default_nettype none

package exec_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int REG_COUNT      = 16;
    localparam int WB_ADDR_WIDTH  = 5;
    localparam int OPCODE_WIDTH   = 4;

    // Number of register stages between issue and the ALU result
    localparam int ALU_DEPTH = 3;

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [2*DATA_WIDTH-1:0]   product_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [WB_ADDR_WIDTH-1:0]  wb_addr_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        MUL  = 4'h3,
        AND  = 4'h4,
        OR   = 4'h5,
        NOT  = 4'h6,
        SATP = 4'h7,
        SATN = 4'h8,
        BGT  = 4'h9,
        BEQ  = 4'ha,
        MOV  = 4'hb
    } opcode_t;

    // Word addresses 0 up to ADDR_REG_LAST map straight onto the registers
    localparam wb_addr_t ADDR_REG_LAST = 5'd15;
    localparam wb_addr_t ADDR_INSTR    = 5'd16;
    localparam wb_addr_t ADDR_STATUS   = 5'd17;

    // Instruction word layout, each field is one register index or opcode wide
    localparam int OP_LSB   = 0;
    localparam int DEST_LSB = 4;
    localparam int SRCA_LSB = 8;
    localparam int SRCB_LSB = 12;

endpackage

`default_nettype wire

// ==== src/exec_control.sv ====
// ==========================================================
// Wishbone slave decode, instruction issue and hazard stall.
// Carries opcode and destination alongside the ALU pipeline.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_control (
    input  wire                 clock,
    input  wire                 arst_n,
    input  wire                 cyc,
    input  wire                 stb,
    input  wire                 we,
    input  exec_pkg::wb_addr_t  adr,
    input  exec_pkg::data_t     dat_w,
    input  exec_pkg::data_t     rd_data_a,
    output exec_pkg::data_t     dat_r,
    output logic                ack,
    output exec_pkg::reg_addr_t rd_addr_a,
    output exec_pkg::reg_addr_t rd_addr_b,
    output logic                issue_valid,
    output exec_pkg::opcode_t   issue_op,
    output exec_pkg::opcode_t   wb_op,
    output exec_pkg::reg_addr_t wb_dest,
    output logic                host_wr_en,
    output exec_pkg::reg_addr_t host_wr_addr,
    output exec_pkg::data_t     host_wr_data
);

    import exec_pkg::*;

    // Delay line of in-flight instructions, entry 0 is the youngest
    opcode_t                dly_op   [ALU_DEPTH];
    reg_addr_t              dly_dest [ALU_DEPTH];
    logic [ALU_DEPTH-1:0]   sb_valid;

    logic      req;
    logic      is_reg;
    logic      is_instr;
    logic      is_status;
    logic      hazard;
    logic      busy;
    reg_addr_t src_a;
    reg_addr_t src_b;
    reg_addr_t issue_dest;

    assign req       = cyc && stb;
    assign is_reg    = (adr <= ADDR_REG_LAST);
    assign is_instr  = (adr == ADDR_INSTR);
    assign is_status = (adr == ADDR_STATUS);

    assign src_a      = dat_w[SRCA_LSB +: REG_ADDR_WIDTH];
    assign src_b      = dat_w[SRCB_LSB +: REG_ADDR_WIDTH];
    assign issue_dest = dat_w[DEST_LSB +: REG_ADDR_WIDTH];

    // Operands are read in the acknowledge cycle, the master holds adr and dat_w
    assign rd_addr_a = is_instr ? src_a : adr[REG_ADDR_WIDTH-1:0];
    assign rd_addr_b = src_b;

    assign issue_valid = ack && we && is_instr;
    assign issue_op    = opcode_t'(dat_w[OP_LSB +: OPCODE_WIDTH]);

    assign host_wr_en   = ack && we && is_reg;
    assign host_wr_addr = adr[REG_ADDR_WIDTH-1:0];
    assign host_wr_data = dat_w;

    assign busy = |sb_valid;

    // The final stage writes at the end of this cycle, so only the younger
    // stages can still hold a stale value by the acknowledge cycle
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < ALU_DEPTH - 1; i++) begin
            if (sb_valid[i]) begin
                if (is_instr && we && (dly_dest[i] == src_a || dly_dest[i] == src_b)) begin
                    hazard = 1'b1;
                end
                if (is_reg && dly_dest[i] == adr[REG_ADDR_WIDTH-1:0]) begin
                    hazard = 1'b1;
                end
            end
        end
        // A host write must not land together with a final-stage writeback
        if (is_reg && we && sb_valid[ALU_DEPTH-2]) begin
            hazard = 1'b1;
        end
    end

    always_comb begin
        dat_r = '0;
        if (ack && !we) begin
            if (is_reg) begin
                dat_r = rd_data_a;
            end else if (is_status) begin
                dat_r[0] = busy;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack      <= 1'b0;
            sb_valid <= '0;
            for (int i = 0; i < ALU_DEPTH; i++) begin
                dly_op[i]   <= NOP;
                dly_dest[i] <= '0;
            end
        end else begin
            ack <= req && !ack && !hazard;
            // Idle cycles push a NOP so the line stays aligned with the ALU
            dly_op[0]   <= issue_valid ? issue_op : NOP;
            dly_dest[0] <= issue_valid ? issue_dest : '0;
            sb_valid[0] <= issue_valid && (issue_op != NOP);
            for (int i = 1; i < ALU_DEPTH; i++) begin
                dly_op[i]   <= dly_op[i-1];
                dly_dest[i] <= dly_dest[i-1];
                sb_valid[i] <= sb_valid[i-1];
            end
        end
    end

    assign wb_op   = dly_op[ALU_DEPTH-1];
    assign wb_dest = dly_dest[ALU_DEPTH-1];

endmodule

`default_nettype wire

// ==== src/exec_regfile.sv ====
// ==========================================================
// Sixteen-word register file, two combinational read ports,
// an ALU writeback port and a host write port.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_regfile (
    input  wire                 clock,
    input  wire                 arst_n,
    input  exec_pkg::reg_addr_t rd_addr_a,
    input  exec_pkg::reg_addr_t rd_addr_b,
    input  wire                 wr_en,
    input  exec_pkg::reg_addr_t wr_addr,
    input  exec_pkg::data_t     wr_data,
    input  wire                 host_wr_en,
    input  exec_pkg::reg_addr_t host_wr_addr,
    input  exec_pkg::data_t     host_wr_data,
    output exec_pkg::data_t     rd_data_a,
    output exec_pkg::data_t     rd_data_b
);

    import exec_pkg::*;

    data_t regs [REG_COUNT];

    // Writeback wins if both ports are ever active together
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end else if (host_wr_en) begin
            regs[host_wr_addr] <= host_wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== src/exec_alu_pipe.sv ====
// ==========================================================
// Three-stage integer ALU. The result appears ALU_DEPTH
// cycles after the operands are presented with issue_valid.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_alu_pipe (
    input  wire               clock,
    input  wire               arst_n,
    input  wire               issue_valid,
    input  exec_pkg::opcode_t issue_op,
    input  exec_pkg::data_t   operand_a,
    input  exec_pkg::data_t   operand_b,
    output exec_pkg::data_t   alu_result
);

    import exec_pkg::*;

    opcode_t  s1_op;
    data_t    s1_a;
    data_t    s1_b;
    logic     s2_mul;
    data_t    s2_res;
    product_t s2_prod;
    data_t    s2_res_d;

    // Stage 1 opcode copy, held while no instruction is issued
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_op <= NOP;
        end else if (issue_valid) begin
            s1_op <= issue_op;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            s1_a <= operand_a;
            s1_b <= operand_b;
        end
    end

    // Everything except the product settles within stage 2
    always_comb begin
        s2_res_d = '0;
        case (s1_op)
            ADD:  s2_res_d = s1_a + s1_b;
            SUB:  s2_res_d = s1_a - s1_b;
            AND:  s2_res_d = s1_a & s1_b;
            OR:   s2_res_d = s1_a | s1_b;
            NOT:  s2_res_d = ~s1_a;
            SATP: s2_res_d = ($signed(s1_a) < $signed(s1_b)) ? s1_a : s1_b;
            SATN: s2_res_d = ($signed(s1_a) > $signed(s1_b)) ? s1_a : s1_b;
            BGT:  s2_res_d[0] = ($signed(s1_a) > $signed(s1_b));
            BEQ:  s2_res_d[0] = (s1_a == s1_b);
            MOV:  s2_res_d = s1_a;
            default: s2_res_d = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s2_mul <= 1'b0;
        end else begin
            s2_mul <= (s1_op == MUL);
        end
    end

    always_ff @(posedge clock) begin
        s2_res  <= s2_res_d;
        s2_prod <= product_t'(s1_a) * product_t'(s1_b);
    end

    // Stage 3 keeps only the low word of the product
    always_ff @(posedge clock) begin
        alu_result <= s2_mul ? s2_prod[DATA_WIDTH-1:0] : s2_res;
    end

endmodule

`default_nettype wire

// ==== src/exec_writeback.sv ====
// ==========================================================
// Shapes the ALU result by the delayed opcode and drives the
// register file writeback port.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_writeback (
    input  exec_pkg::opcode_t   wb_op,
    input  exec_pkg::reg_addr_t wb_dest,
    input  exec_pkg::data_t     alu_result,
    output logic                wr_en,
    output exec_pkg::reg_addr_t wr_addr,
    output exec_pkg::data_t     wr_data
);

    import exec_pkg::*;

    always_comb begin
        case (wb_op)
            ADD,
            SUB,
            MUL,
            AND,
            OR,
            NOT,
            SATP,
            SATN,
            MOV: begin
                wr_en   = 1'b1;
                wr_addr = wb_dest;
                wr_data = alu_result;
            end
            BGT,
            BEQ: begin
                // Compares come out of the ALU as a single flag bit
                wr_en   = 1'b1;
                wr_addr = wb_dest;
                wr_data = alu_result[0] ? '1 : '0;
            end
            default: begin
                wr_en   = 1'b0;
                wr_addr = '0;
                wr_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/exec_top.sv ====
// ==========================================================
// Execution unit top level with its Wishbone classic slave
// port. Instantiate this block in the host system.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  wire                clock,
    input  wire                arst_n,
    input  wire                cyc,
    input  wire                stb,
    input  wire                we,
    input  exec_pkg::wb_addr_t adr,
    input  exec_pkg::data_t    dat_w,
    output exec_pkg::data_t    dat_r,
    output logic               ack
);

    import exec_pkg::*;

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    data_t     rd_data_a;
    data_t     rd_data_b;
    logic      issue_valid;
    opcode_t   issue_op;
    opcode_t   wb_op;
    reg_addr_t wb_dest;
    logic      host_wr_en;
    reg_addr_t host_wr_addr;
    data_t     host_wr_data;
    data_t     alu_result;
    logic      wr_en;
    reg_addr_t wr_addr;
    data_t     wr_data;

    exec_control control0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .rd_data_a    (rd_data_a),
        .dat_r        (dat_r),
        .ack          (ack),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .wb_op        (wb_op),
        .wb_dest      (wb_dest),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data)
    );

    exec_regfile regfile0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b)
    );

    // Operands come straight from the register file read ports
    exec_alu_pipe alu0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .operand_a   (rd_data_a),
        .operand_b   (rd_data_b),
        .alu_result  (alu_result)
    );

    exec_writeback writeback0 (
        .wb_op      (wb_op),
        .wb_dest    (wb_dest),
        .alu_result (alu_result),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

endmodule

`default_nettype wire

// ==== sim/exec_clock_gen.sv ====
// ==========================================================
// Testbench clock and reset source. 20 ns clock, reset held
// low over the first two rising edges.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Reset is released on a falling edge, away from the active clock edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/exec_tb.sv ====
// ==========================================================
// Table-driven testbench for the execution unit. Runs a step
// table over the Wishbone port against a shadow register model.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    import exec_pkg::*;

    localparam int          ACK_TIMEOUT   = 50;
    localparam int          DRAIN_LIMIT   = 20;
    localparam int          RESET_TIMEOUT = 10;
    localparam int unsigned RAND_SEED     = 32'hb4f4_afc6;

    typedef enum logic [2:0] {
        STEP_LOAD,
        STEP_ISSUE,
        STEP_READ,
        STEP_STATUS,
        STEP_DRAIN
    } step_kind_t;

    typedef struct packed {
        step_kind_t kind;
        opcode_t    op;
        reg_addr_t  dest;
        reg_addr_t  srca;
        reg_addr_t  srcb;
        logic       rnd;
        data_t      value;
    } step_t;

    logic     clock;
    logic     arst_n;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    data_t    dat_w;
    data_t    dat_r;
    logic     ack;

    step_t steps [$];
    data_t shadow [REG_COUNT];
    int    checks;
    int    value_errors;
    int    timeouts;

    exec_clock_gen clock_gen0 (
        .clock  (clock),
        .arst_n (arst_n)
    );

    exec_top dut0 (
        .clock  (clock),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    // Expected result of one instruction. NOP keeps the old destination value
    function automatic data_t model_result(opcode_t op, data_t a, data_t b, data_t old);
        data_t r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            MUL:     r = a * b;
            AND:     r = a & b;
            OR:      r = a | b;
            NOT:     r = ~a;
            SATP:    r = ($signed(a) <= $signed(b)) ? a : b;
            SATN:    r = ($signed(a) >= $signed(b)) ? a : b;
            BGT:     r = ($signed(a) > $signed(b)) ? 32'hffff_ffff : 32'h0;
            BEQ:     r = (a == b) ? 32'hffff_ffff : 32'h0;
            MOV:     r = a;
            default: r = old;
        endcase
        return r;
    endfunction

    function automatic data_t instr_word(opcode_t op, reg_addr_t dest, reg_addr_t srca,
                                         reg_addr_t srcb);
        data_t w;
        w = '0;
        w[OP_LSB +: OPCODE_WIDTH]     = op;
        w[DEST_LSB +: REG_ADDR_WIDTH] = dest;
        w[SRCA_LSB +: REG_ADDR_WIDTH] = srca;
        w[SRCB_LSB +: REG_ADDR_WIDTH] = srcb;
        return w;
    endfunction

    task automatic add_step(input step_kind_t kind, input opcode_t op, input int dest,
                            input int srca, input int srcb, input logic rnd, input data_t value);
        step_t s;
        s.kind  = kind;
        s.op    = op;
        s.dest  = reg_addr_t'(dest);
        s.srca  = reg_addr_t'(srca);
        s.srcb  = reg_addr_t'(srcb);
        s.rnd   = rnd;
        s.value = value;
        steps.push_back(s);
    endtask

    task automatic build_table;
        // Registers and status straight out of reset
        for (int r = 0; r < REG_COUNT; r++) add_step(STEP_READ, NOP, r, 0, 0, 0, 0);
        add_step(STEP_STATUS, NOP, 0, 0, 0, 0, 32'h0);
        // Random fill of every register and read back
        for (int r = 0; r < REG_COUNT; r++) add_step(STEP_LOAD, NOP, r, 0, 0, 1, 0);
        for (int r = 0; r < REG_COUNT; r++) add_step(STEP_READ, NOP, r, 0, 0, 0, 0);
        // Every opcode on random sources r8 to r15 and read back right after issue
        for (int o = ADD; o <= MOV; o++) begin
            add_step(STEP_ISSUE, opcode_t'(o), 4 + o % 4, 8 + o % 8, 8 + (o + 3) % 8, 0, 0);
            add_step(STEP_READ, NOP, 4 + o % 4, 0, 0, 0, 0);
        end
        // Signed edge operands in r0 to r3
        add_step(STEP_LOAD, NOP, 0, 0, 0, 0, 32'h8000_0000);
        add_step(STEP_LOAD, NOP, 1, 0, 0, 0, 32'h7fff_ffff);
        add_step(STEP_LOAD, NOP, 2, 0, 0, 0, 32'hffff_ffff);
        add_step(STEP_LOAD, NOP, 3, 0, 0, 0, 32'h0000_0001);
        for (int o = ADD; o <= MOV; o++) begin
            add_step(STEP_ISSUE, opcode_t'(o), 4 + o % 4, o % 4, (o + 1) % 4, 0, 0);
            add_step(STEP_READ, NOP, 4 + o % 4, 0, 0, 0, 0);
        end
        // Compares with known outcomes and equal operands, followed by a NOP
        // aimed at a register that holds all ones
        add_step(STEP_ISSUE, BGT, 5, 1, 0, 0, 0);
        add_step(STEP_ISSUE, BGT, 6, 0, 1, 0, 0);
        add_step(STEP_ISSUE, BEQ, 7, 2, 2, 0, 0);
        add_step(STEP_ISSUE, BEQ, 4, 2, 3, 0, 0);
        add_step(STEP_ISSUE, BGT, 8, 3, 3, 0, 0);
        add_step(STEP_ISSUE, NOP, 5, 9, 10, 0, 0);
        for (int r = 4; r <= 8; r++) add_step(STEP_READ, NOP, r, 0, 0, 0, 0);
        // Dependent chain issued back to back where each step reads the previous result
        add_step(STEP_ISSUE, ADD, 10, 8, 9, 0, 0);
        add_step(STEP_ISSUE, SUB, 11, 10, 0, 0, 0);
        add_step(STEP_ISSUE, MUL, 12, 11, 10, 0, 0);
        add_step(STEP_ISSUE, SATN, 13, 12, 11, 0, 0);
        add_step(STEP_ISSUE, BEQ, 14, 13, 13, 0, 0);
        add_step(STEP_ISSUE, MOV, 15, 14, 0, 0, 0);
        for (int r = 15; r >= 10; r--) add_step(STEP_READ, NOP, r, 0, 0, 0, 0);
        // Busy flag right after an issue and idle again once drained
        add_step(STEP_ISSUE, ADD, 9, 1, 3, 0, 0);
        add_step(STEP_STATUS, NOP, 0, 0, 0, 0, 32'h1);
        add_step(STEP_DRAIN, NOP, 0, 0, 0, 0, 0);
        add_step(STEP_STATUS, NOP, 0, 0, 0, 0, 32'h0);
        add_step(STEP_READ, NOP, 9, 0, 0, 0, 0);
    endtask

    // Starts on a falling edge and returns on the falling edge after the ack cycle
    task automatic wb_access(input logic write, input wb_addr_t addr, input data_t wdata,
                             output data_t rdata);
        int cycles;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        rdata = '0;
        cycles = 0;
        @(negedge clock);
        while (!ack && cycles < ACK_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (ack) begin
            rdata = dat_r;
        end else begin
            $display("Timeout: no acknowledge within %0d cycles for address %0d",
                     ACK_TIMEOUT, addr);
            timeouts++;
        end
        @(negedge clock);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input data_t data);
        data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_idle;
        data_t status;
        int    polls;
        polls = 0;
        wb_read(ADDR_STATUS, status);
        while (status[0] && polls < DRAIN_LIMIT) begin
            wb_read(ADDR_STATUS, status);
            polls++;
        end
        if (status[0]) begin
            $display("Timeout: pipeline still busy after %0d status polls", DRAIN_LIMIT);
            timeouts++;
        end
    endtask

    task automatic apply_step(input step_t s);
        data_t value;
        data_t got;
        case (s.kind)
            STEP_LOAD: begin
                value = s.rnd ? data_t'($urandom) : s.value;
                wb_write(wb_addr_t'(s.dest), value);
                shadow[s.dest] = value;
            end
            STEP_ISSUE: begin
                wb_write(ADDR_INSTR, instr_word(s.op, s.dest, s.srca, s.srcb));
                shadow[s.dest] = model_result(s.op, shadow[s.srca], shadow[s.srcb],
                                              shadow[s.dest]);
            end
            STEP_READ: begin
                wb_read(wb_addr_t'(s.dest), got);
                checks++;
                if (got !== shadow[s.dest]) begin
                    $display("ERROR at %0t: r%0d read 0x%08h, expected 0x%08h",
                             $time, s.dest, got, shadow[s.dest]);
                    value_errors++;
                end
            end
            STEP_STATUS: begin
                wb_read(ADDR_STATUS, got);
                checks++;
                if (got !== s.value) begin
                    $display("ERROR at %0t: status read 0x%08h, expected 0x%08h",
                             $time, got, s.value);
                    value_errors++;
                end
            end
            default: wait_idle();
        endcase
    endtask

    initial begin
        int unsigned seed;
        int          cycles;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        dat_w        = '0;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        seed         = RAND_SEED;
        void'($urandom(seed));
        for (int r = 0; r < REG_COUNT; r++) shadow[r] = '0;
        build_table();
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        @(negedge clock);
        foreach (steps[i]) apply_step(steps[i]);
        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/exec_pkg.sv
src/exec_control.sv
src/exec_regfile.sv
src/exec_alu_pipe.sv
src/exec_writeback.sv
src/exec_top.sv
sim/exec_clock_gen.sv
sim/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  # RTL in compile order, package first
  - src/exec_pkg.sv
  - src/exec_control.sv
  - src/exec_regfile.sv
  - src/exec_alu_pipe.sv
  - src/exec_writeback.sv
  - src/exec_top.sv

  # Testbench, top module exec_tb
  - target: simulation
    files:
      - sim/exec_clock_gen.sv
      - sim/exec_tb.sv
